// ==== axi_mem_pkg.sv ====
package axi_mem_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 16;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ID_WIDTH   = 4;

  // Byte-in-word select bits
  localparam int WORD_LSB       = $clog2(STRB_WIDTH);
  localparam int MEM_ADDR_WIDTH = ADDR_WIDTH - WORD_LSB;
  localparam int MEM_DEPTH      = 1 << MEM_ADDR_WIDTH;

  typedef logic [ADDR_WIDTH-1:0]     axi_addr_t;
  typedef logic [DATA_WIDTH-1:0]     axi_data_t;
  typedef logic [STRB_WIDTH-1:0]     axi_strb_t;
  typedef logic [ID_WIDTH-1:0]       axi_id_t;
  typedef logic [7:0]                axi_len_t;
  typedef logic [2:0]                axi_size_t;
  typedef logic [1:0]                axi_resp_t;
  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // ------------------------------------------------------------------------
  // Channel words
  // ------------------------------------------------------------------------

  // AR and AW request as seen on the top ports
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ax_t;

  // Write address without len, a burst ends on wlast
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_aw_req_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  // One array write
  typedef struct packed {
    logic      en;
    mem_addr_t addr;
    axi_data_t data;
    axi_strb_t strb;
  } mem_wr_t;

endpackage

// ==== axi_skid_buffer.sv ====
`timescale 1ns/1ps

module axi_skid_buffer #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Upstream side
  input  logic                  i_valid,
  input  logic [DATA_WIDTH-1:0] i_data,
  output logic                  o_ready,

  // Downstream side
  output logic                  o_valid,
  output logic [DATA_WIDTH-1:0] o_data,
  input  logic                  i_ready
);

  // Skid register, holds the item caught while downstream stalls
  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_full;

  // Buffer is full exactly when upstream ready is low
  assign skid_full = !o_ready;

  // ------------------------------------------------------------------------
  // Ready register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_ready <= 1'b1;
    end else if (o_ready && i_valid && !i_ready) begin
      // Item accepted but not passed on
      o_ready <= 1'b0;
    end else if (skid_full && i_ready) begin
      o_ready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (o_ready) begin
      skid_data <= i_data;
    end
  end

  // Pass straight through while empty
  assign o_valid = skid_full || i_valid;
  assign o_data  = skid_full ? skid_data : i_data;

endmodule

// ==== axi_mem_write_ctrl.sv ====
`timescale 1ns/1ps

module axi_mem_write_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     i_aw_valid,
  input  axi_mem_pkg::axi_aw_req_t i_aw,
  output logic                     o_aw_ready,

  input  logic                     i_w_valid,
  input  axi_mem_pkg::axi_w_t      i_w,
  output logic                     o_w_ready,

  output logic                     o_b_valid,
  output axi_mem_pkg::axi_b_t      o_b,
  input  logic                     i_b_ready,

  output axi_mem_pkg::mem_wr_t     o_mem_wr
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BURST,
    ST_RESP
  } state_t;

  state_t     state;
  state_t     state_next;

  // Burst context
  axi_id_t    id_q;
  axi_id_t    id_next;
  axi_addr_t  addr_q;
  axi_addr_t  addr_next;
  axi_size_t  size_q;
  axi_size_t  size_next;
  axi_burst_t burst_q;
  axi_burst_t burst_next;

  logic       b_valid_next;
  axi_id_t    b_id;
  axi_id_t    b_id_next;
  logic       b_free;

  // B slot can take a new response this cycle
  assign b_free = !o_b_valid || i_b_ready;

  // ------------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------------
  always_comb begin
    state_next   = state;
    id_next      = id_q;
    addr_next    = addr_q;
    size_next    = size_q;
    burst_next   = burst_q;
    b_valid_next = o_b_valid && !i_b_ready;
    b_id_next    = b_id;
    o_aw_ready   = 1'b0;
    o_w_ready    = 1'b0;
    o_mem_wr     = '{en: 1'b0, addr: '0, data: i_w.data, strb: i_w.strb};

    case (state)
      ST_IDLE: begin
        o_aw_ready = 1'b1;
        if (i_aw_valid) begin
          o_w_ready  = 1'b1;
          state_next = ST_BURST;
          id_next    = i_aw.id;
          addr_next  = i_aw.addr;
          size_next  = i_aw.size;
          burst_next = i_aw.burst;

          // First beat goes with the address
          if (i_w_valid) begin
            o_mem_wr.en   = 1'b1;
            o_mem_wr.addr = i_aw.addr[ADDR_WIDTH-1:WORD_LSB];
            if (i_aw.burst != BURST_FIXED) begin
              addr_next = i_aw.addr + (axi_addr_t'(1) << i_aw.size);
            end
            if (i_w.last) begin
              if (b_free) begin
                state_next   = ST_IDLE;
                b_valid_next = 1'b1;
                b_id_next    = i_aw.id;
              end else begin
                state_next = ST_RESP;
              end
            end
          end
        end
      end

      ST_BURST: begin
        // Data beats never wait on B, only the final response does
        o_w_ready = 1'b1;
        if (i_w_valid) begin
          o_mem_wr.en   = 1'b1;
          o_mem_wr.addr = addr_q[ADDR_WIDTH-1:WORD_LSB];
          if (burst_q != BURST_FIXED) begin
            addr_next = addr_q + (axi_addr_t'(1) << size_q);
          end
          if (i_w.last) begin
            if (b_free) begin
              state_next   = ST_IDLE;
              b_valid_next = 1'b1;
              b_id_next    = id_q;
            end else begin
              state_next = ST_RESP;
            end
          end
        end
      end

      ST_RESP: begin
        // Previous B drains, ours takes its place
        if (i_b_ready) begin
          state_next   = ST_IDLE;
          b_valid_next = 1'b1;
          b_id_next    = id_q;
        end
      end

      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      o_b_valid <= 1'b0;
    end else begin
      state     <= state_next;
      o_b_valid <= b_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    id_q    <= id_next;
    addr_q  <= addr_next;
    size_q  <= size_next;
    burst_q <= burst_next;
    b_id    <= b_id_next;
  end

  assign o_b = '{id: b_id, resp: RESP_OKAY};

endmodule

// ==== axi_mem_read_ctrl.sv ====
`timescale 1ns/1ps

module axi_mem_read_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   i_ar_valid,
  input  axi_mem_pkg::axi_ax_t   i_ar,
  output logic                   o_ar_ready,

  // Array read port
  output logic                   o_rd_en,
  output axi_mem_pkg::mem_addr_t o_rd_addr,

  // R control, data comes from the array
  output logic                   o_r_valid,
  output axi_mem_pkg::axi_id_t   o_r_id,
  output logic                   o_r_last,
  input  logic                   i_r_ready
);
  import axi_mem_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_BURST
  } state_t;

  state_t     state;
  state_t     state_next;

  axi_id_t    id_q;
  axi_id_t    id_next;
  axi_addr_t  addr_q;
  axi_addr_t  addr_next;
  axi_len_t   len_q;
  axi_len_t   len_next;
  axi_size_t  size_q;
  axi_size_t  size_next;
  axi_burst_t burst_q;
  axi_burst_t burst_next;

  logic       ar_ready_next;
  logic       r_valid_next;
  axi_id_t    r_id_next;
  logic       r_last_next;
  logic       r_free;

  // R register empty or being drained
  assign r_free = !o_r_valid || i_r_ready;

  // ------------------------------------------------------------------------
  // Beat issue
  // ------------------------------------------------------------------------
  always_comb begin
    axi_addr_t  cur_addr;
    axi_len_t   cur_len;
    axi_size_t  cur_size;
    axi_burst_t cur_burst;
    axi_id_t    cur_id;

    state_next    = state;
    id_next       = id_q;
    addr_next     = addr_q;
    len_next      = len_q;
    size_next     = size_q;
    burst_next    = burst_q;
    ar_ready_next = o_ar_ready;
    r_valid_next  = o_r_valid && !i_r_ready;
    r_id_next     = o_r_id;
    r_last_next   = o_r_last;
    o_rd_en       = 1'b0;
    o_rd_addr     = '0;

    // Idle works straight from the AR word
    if (state == ST_IDLE) begin
      cur_id    = i_ar.id;
      cur_addr  = i_ar.addr;
      cur_len   = i_ar.len;
      cur_size  = i_ar.size;
      cur_burst = i_ar.burst;
    end else begin
      cur_id    = id_q;
      cur_addr  = addr_q;
      cur_len   = len_q;
      cur_size  = size_q;
      cur_burst = burst_q;
    end

    if (state == ST_IDLE && i_ar_valid && o_ar_ready) begin
      state_next    = ST_BURST;
      ar_ready_next = 1'b0;
      id_next       = i_ar.id;
      addr_next     = i_ar.addr;
      len_next      = i_ar.len;
      size_next     = i_ar.size;
      burst_next    = i_ar.burst;
    end

    if ((state == ST_BURST || (i_ar_valid && o_ar_ready)) && r_free) begin
      o_rd_en      = 1'b1;
      o_rd_addr    = cur_addr[ADDR_WIDTH-1:WORD_LSB];
      r_valid_next = 1'b1;
      r_id_next    = cur_id;
      r_last_next  = (cur_len == '0);
      if (cur_burst != BURST_FIXED) begin
        addr_next = cur_addr + (axi_addr_t'(1) << cur_size);
      end
      len_next = cur_len - 1'b1;
      if (cur_len == '0) begin
        state_next    = ST_IDLE;
        ar_ready_next = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      o_ar_ready <= 1'b1;
      o_r_valid  <= 1'b0;
    end else begin
      state      <= state_next;
      o_ar_ready <= ar_ready_next;
      o_r_valid  <= r_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    id_q     <= id_next;
    addr_q   <= addr_next;
    len_q    <= len_next;
    size_q   <= size_next;
    burst_q  <= burst_next;
    o_r_id   <= r_id_next;
    o_r_last <= r_last_next;
  end

endmodule

// ==== axi_mem_array.sv ====
`timescale 1ns/1ps

module axi_mem_array (
  input  logic                   clk,

  // Byte-strobed write port
  input  axi_mem_pkg::mem_wr_t   i_wr,

  // Registered read port
  input  logic                   i_rd_en,
  input  axi_mem_pkg::mem_addr_t i_rd_addr,
  output axi_mem_pkg::axi_data_t o_rd_data
);
  import axi_mem_pkg::*;

  axi_data_t mem [MEM_DEPTH];

  // ------------------------------------------------------------------------
  // Write, one byte lane per strobe bit
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (i_wr.en && i_wr.strb[i]) begin
        mem[i_wr.addr][8*i +: 8] <= i_wr.data[8*i +: 8];
      end
    end
  end

  // Read data holds between reads
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

// ==== axi_mem.sv ====
`timescale 1ns/1ps

module axi_mem (
  input  logic                 clk,
  input  logic                 rst_n,

  // AW channel
  input  logic                 i_aw_valid,
  input  axi_mem_pkg::axi_ax_t i_aw,
  output logic                 o_aw_ready,

  // W channel
  input  logic                 i_w_valid,
  input  axi_mem_pkg::axi_w_t  i_w,
  output logic                 o_w_ready,

  // B channel
  output logic                 o_b_valid,
  output axi_mem_pkg::axi_b_t  o_b,
  input  logic                 i_b_ready,

  // AR channel
  input  logic                 i_ar_valid,
  input  axi_mem_pkg::axi_ax_t i_ar,
  output logic                 o_ar_ready,

  // R channel
  output logic                 o_r_valid,
  output axi_mem_pkg::axi_r_t  o_r,
  input  logic                 i_r_ready
);
  import axi_mem_pkg::*;

  axi_aw_req_t aw_req;
  axi_aw_req_t aw_sk;
  logic        aw_sk_valid;
  logic        aw_sk_ready;

  axi_w_t      w_sk;
  logic        w_sk_valid;
  logic        w_sk_ready;

  mem_wr_t     mem_wr;
  logic        rd_en;
  mem_addr_t   rd_addr;
  axi_data_t   rd_data;
  axi_id_t     r_id;
  logic        r_last;

  // ------------------------------------------------------------------------
  // Write path
  // ------------------------------------------------------------------------

  // len is not needed, wlast closes the burst
  assign aw_req = '{id: i_aw.id, addr: i_aw.addr, size: i_aw.size, burst: i_aw.burst};

  axi_skid_buffer #(
    .DATA_WIDTH($bits(axi_aw_req_t))
  ) u_aw_skid (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_aw_valid),
    .i_data (aw_req),
    .o_ready(o_aw_ready),
    .o_valid(aw_sk_valid),
    .o_data (aw_sk),
    .i_ready(aw_sk_ready)
  );

  axi_skid_buffer #(
    .DATA_WIDTH($bits(axi_w_t))
  ) u_w_skid (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_w_valid),
    .i_data (i_w),
    .o_ready(o_w_ready),
    .o_valid(w_sk_valid),
    .o_data (w_sk),
    .i_ready(w_sk_ready)
  );

  axi_mem_write_ctrl u_write_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_aw_valid(aw_sk_valid),
    .i_aw      (aw_sk),
    .o_aw_ready(aw_sk_ready),
    .i_w_valid (w_sk_valid),
    .i_w       (w_sk),
    .o_w_ready (w_sk_ready),
    .o_b_valid (o_b_valid),
    .o_b       (o_b),
    .i_b_ready (i_b_ready),
    .o_mem_wr  (mem_wr)
  );

  // ------------------------------------------------------------------------
  // Read path and storage
  // ------------------------------------------------------------------------
  axi_mem_read_ctrl u_read_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_ar_valid(i_ar_valid),
    .i_ar      (i_ar),
    .o_ar_ready(o_ar_ready),
    .o_rd_en   (rd_en),
    .o_rd_addr (rd_addr),
    .o_r_valid (o_r_valid),
    .o_r_id    (r_id),
    .o_r_last  (r_last),
    .i_r_ready (i_r_ready)
  );

  axi_mem_array u_array (
    .clk      (clk),
    .i_wr     (mem_wr),
    .i_rd_en  (rd_en),
    .i_rd_addr(rd_addr),
    .o_rd_data(rd_data)
  );

  // Array data lands with the registered R control
  assign o_r = '{id: r_id, data: rd_data, resp: RESP_OKAY, last: r_last};

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset released just after an edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1;
    o_rst_n = 1'b1;
  end

endmodule

// ==== axi_mem_assertions.sv ====
`timescale 1ns/1ps

module axi_mem_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 i_b_valid,
  input axi_mem_pkg::axi_b_t  i_b,
  input logic                 i_b_ready,
  input logic                 i_r_valid,
  input axi_mem_pkg::axi_r_t  i_r,
  input logic                 i_r_ready,
  input logic                 i_ar_valid,
  input axi_mem_pkg::axi_ax_t i_ar,
  input logic                 i_ar_ready
);
  import axi_mem_pkg::*;

  // Burst lengths of accepted AR requests with up to two in flight
  axi_len_t len_q [2];
  logic     wr_ptr;
  logic     rd_ptr;
  axi_len_t beat;

  // Number of failed assertions so far
  int       assert_errors = 0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      beat   <= '0;
    end else begin
      if (i_ar_valid && i_ar_ready) begin
        wr_ptr <= !wr_ptr;
      end
      if (i_r_valid && i_r_ready) begin
        if (i_r.last) begin
          beat   <= '0;
          rd_ptr <= !rd_ptr;
        end else begin
          beat <= beat + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_ar_valid && i_ar_ready) begin
      len_q[wr_ptr] <= i_ar.len;
    end
  end

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_b_valid && !i_b_ready |=> i_b_valid && $stable(i_b))
    else begin
      $error("B valid dropped or payload changed before acceptance");
      assert_errors++;
    end

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_r_valid && !i_r_ready |=> i_r_valid && $stable(i_r))
    else begin
      $error("R valid dropped or payload changed before acceptance");
      assert_errors++;
    end

  r_last_final: assert property (@(posedge clk) disable iff (!rst_n)
    i_r_valid |-> (i_r.last == (beat == len_q[rd_ptr])))
    else begin
      $error("R last does not match the final beat of the burst");
      assert_errors++;
    end

  idle_in_reset: assert property (@(posedge clk)
    !rst_n |=> !i_b_valid && !i_r_valid)
    else begin
      $error("B or R valid high during reset");
      assert_errors++;
    end

endmodule

bind axi_mem axi_mem_assertions u_assertions (
  .clk       (clk),
  .rst_n     (rst_n),
  .i_b_valid (o_b_valid),
  .i_b       (o_b),
  .i_b_ready (i_b_ready),
  .i_r_valid (o_r_valid),
  .i_r       (o_r),
  .i_r_ready (i_r_ready),
  .i_ar_valid(i_ar_valid),
  .i_ar      (i_ar),
  .i_ar_ready(o_ar_ready)
);

// ==== axi_mem_tb.sv ====
`timescale 1ns/1ps

module axi_mem_tb;
  import axi_mem_pkg::*;

  // Room for about 200 bursts of up to 40 cycles under stalls plus margin
  localparam int TIMEOUT_CYCLES = 20000;

  localparam int STRB_FULL = 0;
  localparam int STRB_LANE = 1;
  localparam int STRB_RAND = 2;

  logic       clk;
  logic       rst_n;
  logic       i_aw_valid;
  axi_ax_t    i_aw;
  logic       o_aw_ready;
  logic       i_w_valid;
  axi_w_t     i_w;
  logic       o_w_ready;
  logic       o_b_valid;
  axi_b_t     o_b;
  logic       i_b_ready;
  logic       i_ar_valid;
  axi_ax_t    i_ar;
  logic       o_ar_ready;
  logic       o_r_valid;
  axi_r_t     o_r;
  logic       i_r_ready;

  // Reference memory with one entry per byte address
  logic [7:0] ref_mem [256];

  integer     seed;
  string      test_name;
  int         errors;
  int         checks;
  int         tests;
  int         failed_tests;
  int         test_errors;
  int         cycles;
  logic       stall_en;
  logic       gap_en;

  // Outstanding reads and expected B ids
  axi_ax_t    ar_q [$];
  axi_id_t    b_q [$];
  int         r_beat;
  int         r_sent;
  int         r_done;
  int         b_sent;
  int         b_done;

  tb_clock_gen #(
    .PERIOD_NS   (100),
    .RESET_CYCLES(10)
  ) u_clock_gen (
    .o_clk  (clk),
    .o_rst_n(rst_n)
  );

  axi_mem axi_mem_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_aw_valid(i_aw_valid),
    .i_aw      (i_aw),
    .o_aw_ready(o_aw_ready),
    .i_w_valid (i_w_valid),
    .i_w       (i_w),
    .o_w_ready (o_w_ready),
    .o_b_valid (o_b_valid),
    .o_b       (o_b),
    .i_b_ready (i_b_ready),
    .i_ar_valid(i_ar_valid),
    .i_ar      (i_ar),
    .o_ar_ready(o_ar_ready),
    .o_r_valid (o_r_valid),
    .o_r       (o_r),
    .i_r_ready (i_r_ready)
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic axi_addr_t beat_addr(input axi_addr_t start, input axi_size_t size,
                                          input axi_burst_t burst, input int beat);
    if (burst == BURST_FIXED) begin
      return start;
    end
    return start + axi_addr_t'(beat << size);
  endfunction

  function automatic axi_data_t expected_word(input axi_addr_t start, input axi_size_t size,
                                              input axi_burst_t burst, input int beat);
    axi_addr_t a;
    a = beat_addr(start, size, burst, beat);
    return {ref_mem[{a[7:1], 1'b1}], ref_mem[{a[7:1], 1'b0}]};
  endfunction

  function automatic axi_data_t fill_word(input axi_addr_t a);
    return {a | 8'h01, a & 8'hfe} ^ 16'h5ac3;
  endfunction

  task automatic store_beat(input axi_addr_t a, input axi_data_t data, input axi_strb_t strb);
    for (int lane = 0; lane < STRB_WIDTH; lane++) begin
      if (strb[lane]) begin
        ref_mem[{a[7:1], lane[0]}] = data[8*lane +: 8];
      end
    end
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic report_test();
    tests++;
    if (errors == test_errors) begin
      $display("test %-10s ok", test_name);
    end else begin
      failed_tests++;
      $display("test %-10s FAILED with %0d errors", test_name, errors - test_errors);
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus drivers that change inputs 1 ns after the rising edge
  // --------------------------------------------------------------------------
  task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input int len,
                             input axi_size_t size, input axi_burst_t burst,
                             input int strb_mode, input bit use_fill);
    axi_addr_t a;
    axi_data_t data;
    axi_strb_t strb;
    logic      hs;
    b_q.push_back(id);
    b_sent++;
    i_aw       = '{id: id, addr: addr, len: axi_len_t'(len), size: size, burst: burst};
    i_aw_valid = 1'b1;
    do begin
      @(negedge clk);
      hs = o_aw_ready;
      @(posedge clk);
      #1;
    end while (!hs);
    i_aw_valid = 1'b0;
    for (int beat = 0; beat <= len; beat++) begin
      if (gap_en) begin
        repeat ($unsigned($random(seed)) % 3) begin
          @(posedge clk);
          #1;
        end
      end
      a    = beat_addr(addr, size, burst, beat);
      data = use_fill ? fill_word(a) : axi_data_t'($random(seed));
      case (strb_mode)
        STRB_FULL: strb = '1;
        STRB_LANE: strb = axi_strb_t'(1) << a[0];
        default:   strb = axi_strb_t'($random(seed));
      endcase
      i_w       = '{data: data, strb: strb, last: (beat == len)};
      i_w_valid = 1'b1;
      do begin
        @(negedge clk);
        hs = o_w_ready;
        @(posedge clk);
        #1;
      end while (!hs);
      i_w_valid = 1'b0;
      store_beat(a, data, strb);
    end
    wait (b_done == b_sent);
    @(posedge clk);
    #1;
  endtask

  task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input int len,
                            input axi_size_t size, input axi_burst_t burst);
    logic hs;
    i_ar = '{id: id, addr: addr, len: axi_len_t'(len), size: size, burst: burst};
    ar_q.push_back(i_ar);
    r_sent++;
    i_ar_valid = 1'b1;
    do begin
      @(negedge clk);
      hs = o_ar_ready;
      @(posedge clk);
      #1;
    end while (!hs);
    i_ar_valid = 1'b0;
    wait (r_done == r_sent);
    @(posedge clk);
    #1;
  endtask

  // Random response back-pressure
  always @(posedge clk) begin
    #1;
    if (stall_en) begin
      i_r_ready = ($random(seed) & 3) != 0;
      i_b_ready = ($random(seed) & 3) != 0;
    end else begin
      i_r_ready = 1'b1;
      i_b_ready = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Response checking at mid-cycle where all signals are stable
  // --------------------------------------------------------------------------
  always @(negedge clk) begin : compare_responses
    axi_ax_t ar;
    if (rst_n) begin
      if (o_b_valid && i_b_ready) begin
        if (b_q.size() == 0) begin
          errors++;
          $display("B response with id %h arrived with no write outstanding", o_b.id);
        end else begin
          check("bid", b_q.pop_front(), o_b.id);
          check("bresp", RESP_OKAY, o_b.resp);
        end
        b_done++;
      end
      if (o_r_valid && i_r_ready) begin
        if (ar_q.size() == 0) begin
          errors++;
          $display("R beat with id %h arrived with no read outstanding", o_r.id);
        end else begin
          ar = ar_q[0];
          check("rdata", expected_word(ar.addr, ar.size, ar.burst, r_beat), o_r.data);
          check("rid", ar.id, o_r.id);
          check("rresp", RESP_OKAY, o_r.resp);
          check("rlast", r_beat == ar.len, o_r.last);
          if (r_beat == ar.len) begin
            void'(ar_q.pop_front());
            r_beat = 0;
            r_done++;
          end else begin
            r_beat++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a handshake or response never completed", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    int         len;
    axi_size_t  size;
    axi_addr_t  addr;
    axi_burst_t burst;
    seed         = 32'hb49;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    cycles       = 0;
    r_beat       = 0;
    r_sent       = 0;
    r_done       = 0;
    b_sent       = 0;
    b_done       = 0;
    stall_en     = 1'b0;
    gap_en       = 1'b0;
    i_aw_valid   = 1'b0;
    i_aw         = '0;
    i_w_valid    = 1'b0;
    i_w          = '0;
    i_b_ready    = 1'b1;
    i_ar_valid   = 1'b0;
    i_ar         = '0;
    i_r_ready    = 1'b1;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;

    begin_test("reset");
    check("o_b_valid", 0, o_b_valid);
    check("o_r_valid", 0, o_r_valid);
    check("o_ar_ready", 1, o_ar_ready);
    check("o_aw_ready", 1, o_aw_ready);
    check("o_w_ready", 1, o_w_ready);
    report_test();

    // Whole array gets a known pattern before any read
    begin_test("fill");
    for (int k = 0; k < 8; k++) begin
      write_burst(axi_id_t'(k), axi_addr_t'(32 * k), 15, 3'd1, BURST_INCR, STRB_FULL, 1'b1);
    end
    for (int k = 0; k < 8; k++) begin
      read_burst(axi_id_t'(k + 8), axi_addr_t'(32 * k), 15, 3'd1, BURST_INCR);
    end
    report_test();

    begin_test("single");
    write_burst(4'h3, 8'h40, 0, 3'd1, BURST_INCR, STRB_FULL, 1'b0);
    read_burst(4'h5, 8'h40, 0, 3'd1, BURST_INCR);
    report_test();

    // Odd address selects the upper lane
    begin_test("strobe");
    write_burst(4'h6, 8'h52, 0, 3'd1, BURST_INCR, STRB_LANE, 1'b0);
    read_burst(4'h7, 8'h52, 0, 3'd1, BURST_INCR);
    write_burst(4'h8, 8'h61, 0, 3'd1, BURST_INCR, STRB_LANE, 1'b0);
    read_burst(4'h9, 8'h60, 0, 3'd1, BURST_INCR);
    report_test();

    begin_test("incr");
    for (int n = 0; n < 20; n++) begin
      len  = $unsigned($random(seed)) % 16;
      size = axi_size_t'($random(seed) & 1);
      addr = axi_addr_t'($random(seed));
      if (size == 3'd1) begin
        addr[0] = 1'b0;
      end
      write_burst(axi_id_t'(n), addr, len, size, BURST_INCR,
                  (size == 3'd0) ? STRB_LANE : STRB_FULL, 1'b0);
      read_burst(axi_id_t'(n + 1), addr, len, size, BURST_INCR);
    end
    report_test();

    begin_test("fixed");
    for (int n = 0; n < 8; n++) begin
      addr = axi_addr_t'($random(seed));
      write_burst(axi_id_t'(n), addr, $unsigned($random(seed)) % 8, 3'd1, BURST_FIXED,
                  STRB_RAND, 1'b0);
      read_burst(axi_id_t'(n + 2), addr, $unsigned($random(seed)) % 8, 3'd1, BURST_FIXED);
    end
    report_test();

    begin_test("stall");
    stall_en = 1'b1;
    gap_en   = 1'b1;
    for (int n = 0; n < 30; n++) begin
      len   = $unsigned($random(seed)) % 16;
      size  = axi_size_t'($random(seed) & 1);
      burst = axi_burst_t'($unsigned($random(seed)) % 3);
      addr  = axi_addr_t'($random(seed));
      write_burst(axi_id_t'(n), addr, len, size, burst, STRB_RAND, 1'b0);
      read_burst(axi_id_t'(n + 3), addr, len, size, burst);
    end
    stall_en = 1'b0;
    gap_en   = 1'b0;
    report_test();

    $display("%0d tests run, %0d failed, %0d checks run, %0d errors, %0d assertion failures",
             tests, failed_tests, checks, errors, axi_mem_inst.u_assertions.assert_errors);
    if (errors == 0 && axi_mem_inst.u_assertions.assert_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== axi_mem.f ====
axi_mem_pkg.sv
axi_skid_buffer.sv
axi_mem_write_ctrl.sv
axi_mem_read_ctrl.sv
axi_mem_array.sv
axi_mem.sv
tb_clock_gen.sv
axi_mem_assertions.sv
axi_mem_tb.sv
